//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -j 0 -f build.f --top-module tb_busy_scoreboard -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_busy_scoreboard)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+rtl
rtl/busy_pkg.sv
rtl/busy_table.sv
rtl/busy_snapshot_ring.sv
rtl/dispatch_ready_stage.sv
rtl/busy_scoreboard_top.sv
dv/busy_checker.sv
dv/tb_busy_scoreboard.sv

//--- dv/busy_checker.sv
`include "busy_macros.svh"

module busy_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  busy_pkg::disp_bundle_t  dispatch,
    input  busy_pkg::wb_bundle_t    writeback,
    input  logic                    make_snapshot,
    input  logic                    recover_snapshot,
    input  logic                    release_snapshot,
    input  busy_pkg::issue_bundle_t issue,
    input  logic                    snapshot_full,
    input  logic                    exp_check,
    input  logic [1:0]              exp_valid,
    input  logic [3:0]              exp_ready,
    output int                      errors,
    output int                      checks
);
    import busy_pkg::*;

    busy_vec_t     model_busy;
    busy_vec_t     model_snap [`SNAP_DEPTH];
    int            head;
    int            tail;
    int            count;
    issue_bundle_t want;
    logic          pending = 1'b0;
    logic          dir_check;
    logic [1:0]    dir_valid;
    logic [3:0]    dir_ready;
    int            err_cnt = 0;
    int            chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // Ready when free, when it is register 0, or when written back this cycle
    function automatic logic src_ready(prf_num_t src);
        logic r;
        r = (src == '0) || !model_busy[src];
        for (int w = 0; w < 4; w++) begin
            r = r || (writeback[w].valid && writeback[w].num == src);
        end
        return r;
    endfunction

    task automatic check_that(input logic ok, input string msg);
        chk_cnt++;
        if (ok !== 1'b1) begin
            err_cnt++;
            $display("mismatch at time %0t: %s", $time, msg);
        end
    endtask

    // Inputs are stable at the rising edge, so the model steps here
    always @(posedge clk) begin
        busy_vec_t old;
        if (!arst_n) begin
            model_busy = '0;
            head       = 0;
            tail       = 0;
            count      = 0;
            pending    = 1'b0;
            for (int i = 0; i < `SNAP_DEPTH; i++) begin
                model_snap[i] = '0;
            end
        end else begin
            old = model_busy;
            for (int i = 0; i < 2; i++) begin
                want[i].valid      = dispatch[i].valid && !(flush || recover_snapshot);
                want[i].dest       = dispatch[i].dest;
                want[i].src0       = dispatch[i].src0;
                want[i].src1       = dispatch[i].src1;
                want[i].src0_ready = src_ready(dispatch[i].src0);
                want[i].src1_ready = src_ready(dispatch[i].src1);
            end
            // The younger slot waits on the older slot's destination
            if (dispatch[0].valid && dispatch[0].dest != '0) begin
                want[1].src0_ready = want[1].src0_ready && dispatch[0].dest != dispatch[1].src0;
                want[1].src1_ready = want[1].src1_ready && dispatch[0].dest != dispatch[1].src1;
            end
            pending   = 1'b1;
            dir_check = exp_check;
            dir_valid = exp_valid;
            dir_ready = exp_ready;
            if (flush) begin
                model_busy = '0;
                head       = 0;
                tail       = 0;
                count      = 0;
            end else if (recover_snapshot) begin
                model_busy = model_snap[tail];
                head       = 0;
                tail       = 0;
                count      = 0;
            end else begin
                for (int i = 0; i < 2; i++) begin
                    if (dispatch[i].valid && dispatch[i].dest != '0) begin
                        model_busy[dispatch[i].dest] = 1'b1;
                    end
                end
                for (int w = 0; w < 4; w++) begin
                    if (writeback[w].valid) begin
                        model_busy[writeback[w].num] = 1'b0;
                    end
                end
                if (release_snapshot) begin
                    if (count > 0) begin
                        tail  = (tail + 1) % `SNAP_DEPTH;
                        count = count - 1;
                    end
                end else if (make_snapshot && count < `SNAP_DEPTH) begin
                    model_snap[head] = old;
                    head             = (head + 1) % `SNAP_DEPTH;
                    count            = count + 1;
                end
            end
        end
    end

    // Outputs settle after the rising edge and are compared half a cycle later
    always @(negedge clk) begin
        if (arst_n && pending) begin
            for (int i = 0; i < 2; i++) begin
                check_that(issue[i].valid === want[i].valid
                           && (!want[i].valid || issue[i] === want[i]),
                           $sformatf("slot %0d issue %h, model %h", i, issue[i], want[i]));
                if (dir_check) begin
                    check_that(issue[i].valid === dir_valid[i] && (!dir_valid[i]
                               || {issue[i].src1_ready, issue[i].src0_ready}
                               === dir_ready[2*i +: 2]),
                               $sformatf("slot %0d valid/ready %b%b%b, table %b%b", i,
                                         issue[i].valid, issue[i].src1_ready,
                                         issue[i].src0_ready, dir_valid[i],
                                         dir_ready[2*i +: 2]));
                end
            end
            check_that(snapshot_full === (count == `SNAP_DEPTH),
                       $sformatf("snapshot_full %b with %0d entries in the model",
                                 snapshot_full, count));
        end
    end

endmodule

//--- dv/tb_busy_scoreboard.sv
module tb_busy_scoreboard;
    import busy_pkg::*;

    localparam int random_rows = 200;

    // Control strobes in ctl are flush, make, recover and release from the top bit down
    typedef struct packed {
        disp_bundle_t dispatch;
        wb_bundle_t   writeback;
        logic [3:0]   ctl;
        logic         check;
        logic [1:0]   exp_valid;
        logic [3:0]   exp_ready;
    } row_t;

    localparam disp_slot_t idle_slot = '0;
    localparam wb_bundle_t no_wb     = '0;

    logic          clk;
    logic          arst_n;
    logic          flush;
    disp_bundle_t  dispatch;
    wb_bundle_t    writeback;
    logic          make_snapshot;
    logic          recover_snapshot;
    logic          release_snapshot;
    issue_bundle_t issue;
    logic          snapshot_full;
    logic          exp_check;
    logic [1:0]    exp_valid;
    logic [3:0]    exp_ready;
    int            errors;
    int            checks;
    row_t          rows [$];

    busy_scoreboard_top busy_scoreboard_top_inst (.*);

    busy_checker busy_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic disp_slot_t to_slot(int d, int s0, int s1);
        disp_slot_t s;
        s.valid = 1'b1;
        s.dest  = prf_num_t'(d);
        s.src0  = prf_num_t'(s0);
        s.src1  = prf_num_t'(s1);
        return s;
    endfunction

    // A number of 0 leaves that writeback port idle
    function automatic wb_bundle_t to_wb(int n0, int n1, int n2, int n3);
        wb_bundle_t b;
        int         n [4];
        n = '{n0, n1, n2, n3};
        for (int w = 0; w < 4; w++) begin
            b[w].valid = n[w] != 0;
            b[w].num   = prf_num_t'(n[w]);
        end
        return b;
    endfunction

    task automatic add_row(input disp_slot_t s0, input disp_slot_t s1, input wb_bundle_t wb,
                           input logic [3:0] ctl, input logic [1:0] ev, input logic [3:0] er);
        row_t r;
        r.dispatch[0] = s0;
        r.dispatch[1] = s1;
        r.writeback   = wb;
        r.ctl         = ctl;
        r.check       = 1'b1;
        r.exp_valid   = ev;
        r.exp_ready   = er;
        rows.push_back(r);
    endtask

    // Ready bits run slot 1 src1, slot 1 src0, slot 0 src1, slot 0 src0
    task automatic add_directed_rows();
        add_row(to_slot(5, 1, 2), to_slot(6, 5, 0), no_wb, 4'h0, 2'b11, 4'b1011);
        add_row(to_slot(0, 5, 6), to_slot(7, 6, 5), no_wb, 4'h0, 2'b11, 4'b0000);
        add_row(to_slot(8, 0, 7), to_slot(0, 0, 0), no_wb, 4'h0, 2'b11, 4'b1101);
        add_row(to_slot(9, 5, 6), to_slot(10, 5, 9), to_wb(5, 0, 0, 0), 4'h0, 2'b11, 4'b0101);
        add_row(to_slot(11, 12, 5), to_slot(12, 6, 7), to_wb(0, 0, 6, 11), 4'h0, 2'b11, 4'b0111);
        add_row(to_slot(0, 11, 12), to_slot(0, 9, 10), no_wb, 4'h0, 2'b11, 4'b0001);
        // Snapshot, more traffic, then recover to the saved state
        add_row(to_slot(20, 0, 0), idle_slot, no_wb, 4'h4, 2'b01, 4'b0011);
        add_row(idle_slot, idle_slot, to_wb(7, 8, 9, 10), 4'h4, 2'b00, 4'b0000);
        add_row(to_slot(30, 7, 20), idle_slot, no_wb, 4'h2, 2'b00, 4'b0000);
        add_row(to_slot(0, 7, 20), to_slot(0, 30, 10), no_wb, 4'h0, 2'b11, 4'b0110);
        // After a release the recover uses the second entry
        add_row(to_slot(21, 0, 0), idle_slot, no_wb, 4'h4, 2'b01, 4'b0011);
        add_row(idle_slot, idle_slot, to_wb(7, 0, 0, 0), 4'h4, 2'b00, 4'b0000);
        add_row(idle_slot, idle_slot, no_wb, 4'h1, 2'b00, 4'b0000);
        add_row(idle_slot, idle_slot, no_wb, 4'h2, 2'b00, 4'b0000);
        add_row(to_slot(0, 7, 21), to_slot(0, 20, 0), no_wb, 4'h0, 2'b11, 4'b1100);
        // Fill the ring, then a fifth make must not overwrite entry 0
        for (int k = 0; k < 4; k++) begin
            add_row(idle_slot, idle_slot, no_wb, 4'h4, 2'b00, 4'b0000);
        end
        add_row(to_slot(22, 0, 0), idle_slot, to_wb(7, 0, 0, 0), 4'h0, 2'b01, 4'b0011);
        add_row(idle_slot, idle_slot, no_wb, 4'h4, 2'b00, 4'b0000);
        add_row(idle_slot, idle_slot, no_wb, 4'h2, 2'b00, 4'b0000);
        add_row(to_slot(0, 7, 22), to_slot(0, 8, 0), no_wb, 4'h0, 2'b11, 4'b1010);
        // Flush wipes the table and the ring
        add_row(to_slot(23, 0, 0), idle_slot, no_wb, 4'h4, 2'b01, 4'b0011);
        add_row(to_slot(24, 23, 0), idle_slot, no_wb, 4'h8, 2'b00, 4'b0000);
        add_row(to_slot(0, 7, 23), to_slot(0, 8, 21), no_wb, 4'h0, 2'b11, 4'b1111);
    endtask

    task automatic drive_row(input row_t r);
        dispatch  = r.dispatch;
        writeback = r.writeback;
        {flush, make_snapshot, recover_snapshot, release_snapshot} = r.ctl;
        exp_check = r.check;
        exp_valid = r.exp_valid;
        exp_ready = r.exp_ready;
    endtask

    initial begin
        row_t r;
        void'($urandom(1379));
        add_directed_rows();
        // Random rows draw from a small register range so dependences are common
        for (int n = 0; n < random_rows; n++) begin
            r = '0;
            for (int i = 0; i < 2; i++) begin
                r.dispatch[i]       = to_slot($urandom % 16, $urandom % 16, $urandom % 16);
                r.dispatch[i].valid = ($urandom % 4) != 0;
            end
            r.writeback = to_wb($urandom % 32, $urandom % 32, $urandom % 32, $urandom % 32);
            r.ctl = {($urandom % 50) == 0, ($urandom % 4) == 0,
                     ($urandom % 25) == 0, ($urandom % 5) == 0};
            rows.push_back(r);
        end
        arst_n = 1'b0;
        drive_row('0);
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[n]) begin
            @(negedge clk);
            drive_row(rows[n]);
        end
        @(negedge clk);
        drive_row('0);
        repeat (2) @(negedge clk);
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        #1;
        limit = (rows.size() + 20) * 20;
        #(limit);
        $display("timeout: the run did not end within %0d time units", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- rtl/busy_macros.svh
`ifndef BUSY_MACROS_SVH
`define BUSY_MACROS_SVH

// Physical register file size and index width
`define PRF_NUM 64
`define PRF_W   6

// Depth of the busy-vector snapshot ring and its pointer width
`define SNAP_DEPTH 4
`define SNAP_W     2

`endif

//--- rtl/busy_pkg.sv
`include "busy_macros.svh"

package busy_pkg;

    typedef logic [`PRF_W-1:0]   prf_num_t;
    typedef logic [`PRF_NUM-1:0] busy_vec_t;

    // One renamed instruction as handed over by the rename map
    typedef struct packed {
        logic     valid;
        prf_num_t dest;
        prf_num_t src0;
        prf_num_t src1;
    } disp_slot_t;

    // Slot 0 holds the older instruction of the pair
    typedef disp_slot_t [1:0] disp_bundle_t;

    // A writeback clears the busy bit of num
    typedef struct packed {
        logic     valid;
        prf_num_t num;
    } wb_port_t;

    typedef wb_port_t [3:0] wb_bundle_t;

    // Dispatched instruction with the readiness of each source
    typedef struct packed {
        logic     valid;
        prf_num_t dest;
        prf_num_t src0;
        prf_num_t src1;
        logic     src0_ready;
        logic     src1_ready;
    } issue_slot_t;

    typedef issue_slot_t [1:0] issue_bundle_t;

endpackage

//--- rtl/busy_scoreboard_top.sv
module busy_scoreboard_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  busy_pkg::disp_bundle_t  dispatch,
    input  busy_pkg::wb_bundle_t    writeback,
    input  logic                    make_snapshot,
    input  logic                    recover_snapshot,
    input  logic                    release_snapshot,
    output busy_pkg::issue_bundle_t issue,
    output logic                    snapshot_full
);
    import busy_pkg::*;

    prf_num_t  rd_num [4];
    logic      busy [4];
    logic      set_valid [2];
    prf_num_t  set_num [2];
    busy_vec_t cur_vec;
    busy_vec_t restore_vec;

    dispatch_ready_stage dispatch_ready_stage_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .recover_snapshot (recover_snapshot),
        .dispatch         (dispatch),
        .busy             (busy),
        .rd_num           (rd_num),
        .set_valid        (set_valid),
        .set_num          (set_num),
        .issue            (issue)
    );

    busy_table busy_table_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .recover_snapshot (recover_snapshot),
        .set_valid        (set_valid),
        .set_num          (set_num),
        .writeback        (writeback),
        .rd_num           (rd_num),
        .restore_vec      (restore_vec),
        .busy             (busy),
        .cur_vec          (cur_vec)
    );

    busy_snapshot_ring busy_snapshot_ring_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .make_snapshot    (make_snapshot),
        .recover_snapshot (recover_snapshot),
        .release_snapshot (release_snapshot),
        .cur_vec          (cur_vec),
        .restore_vec      (restore_vec),
        .snapshot_full    (snapshot_full)
    );

endmodule

//--- rtl/busy_snapshot_ring.sv
`include "busy_macros.svh"

module busy_snapshot_ring (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                make_snapshot,
    input  logic                recover_snapshot,
    input  logic                release_snapshot,
    input  busy_pkg::busy_vec_t cur_vec,
    output busy_pkg::busy_vec_t restore_vec,
    output logic                snapshot_full
);
    import busy_pkg::*;

    busy_vec_t          snap_mem [`SNAP_DEPTH];
    logic [`SNAP_W-1:0] head_ptr;
    logic [`SNAP_W-1:0] tail_ptr;
    // One bit wider than the pointers to tell full from empty
    logic [`SNAP_W:0]   count;

    logic full;
    logic empty;

    assign full  = (count == (`SNAP_W+1)'(`SNAP_DEPTH));
    assign empty = (count == '0);

    // Oldest live snapshot is the one a recover goes back to
    assign restore_vec   = snap_mem[tail_ptr];
    assign snapshot_full = full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            for (int i = 0; i < `SNAP_DEPTH; i++) begin
                snap_mem[i] <= '0;
            end
        end else if (flush || recover_snapshot) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (release_snapshot) begin
            // The load for the oldest snapshot hit, so it is no longer needed
            if (!empty) begin
                tail_ptr <= tail_ptr + 1'b1;
                count    <= count - 1'b1;
            end
        end else if (make_snapshot && !full) begin
            snap_mem[head_ptr] <= cur_vec;
            head_ptr           <= head_ptr + 1'b1;
            count              <= count + 1'b1;
        end
    end

endmodule

//--- rtl/busy_table.sv
module busy_table (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 recover_snapshot,
    input  logic                 set_valid [2],
    input  busy_pkg::prf_num_t   set_num [2],
    input  busy_pkg::wb_bundle_t writeback,
    input  busy_pkg::prf_num_t   rd_num [4],
    input  busy_pkg::busy_vec_t  restore_vec,
    output logic                 busy [4],
    output busy_pkg::busy_vec_t  cur_vec
);
    import busy_pkg::*;

    // Two identical copies so each bank only drives two read muxes
    busy_vec_t bank0;
    busy_vec_t bank1;

    busy_vec_t set_vec;
    busy_vec_t clr_vec;
    logic      cleared [4];

    // Decode the dispatch sets into a one-hot style vector
    always_comb begin
        set_vec = '0;
        for (int i = 0; i < 2; i++) begin
            if (set_valid[i]) begin
                set_vec[set_num[i]] = 1'b1;
            end
        end
        // Register 0 is hardwired to zero and can never become busy
        set_vec[0] = 1'b0;
    end

    always_comb begin
        clr_vec = '0;
        for (int w = 0; w < 4; w++) begin
            if (writeback[w].valid) begin
                clr_vec[writeback[w].num] = 1'b1;
            end
        end
    end

    // A writeback this cycle is already known to produce the value,
    // so it is bypassed into the lookup
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            cleared[p] = 1'b0;
            for (int w = 0; w < 4; w++) begin
                if (writeback[w].valid && (writeback[w].num == rd_num[p])) begin
                    cleared[p] = 1'b1;
                end
            end
        end
    end

    // Ports 0 and 1 read bank 0, ports 2 and 3 read bank 1
    always_comb begin
        busy[0] = !cleared[0] && bank0[rd_num[0]];
        busy[1] = !cleared[1] && bank0[rd_num[1]];
        busy[2] = !cleared[2] && bank1[rd_num[2]];
        busy[3] = !cleared[3] && bank1[rd_num[3]];
    end

    // Clears are applied after sets, so a clear wins for the same register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank0 <= '0;
            bank1 <= '0;
        end else if (flush) begin
            bank0 <= '0;
            bank1 <= '0;
        end else if (recover_snapshot) begin
            bank0 <= restore_vec;
            bank1 <= restore_vec;
        end else begin
            bank0 <= (bank0 | set_vec) & ~clr_vec;
            bank1 <= (bank1 | set_vec) & ~clr_vec;
        end
    end

    assign cur_vec = bank0;

endmodule

//--- rtl/dispatch_ready_stage.sv
module dispatch_ready_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    recover_snapshot,
    input  busy_pkg::disp_bundle_t  dispatch,
    input  logic                    busy [4],
    output busy_pkg::prf_num_t      rd_num [4],
    output logic                    set_valid [2],
    output busy_pkg::prf_num_t      set_num [2],
    output busy_pkg::issue_bundle_t issue
);
    import busy_pkg::*;

    logic          kill;
    logic          older_writes;
    issue_bundle_t issue_d;
    issue_bundle_t payload_q;
    logic [1:0]    valid_q;

    // A flush or recover squashes whatever is dispatched in that cycle
    assign kill = flush | recover_snapshot;

    // Slot 0 can only create a dependence when it writes a real register
    assign older_writes = dispatch[0].valid && (dispatch[0].dest != '0);

    assign rd_num[0] = dispatch[0].src0;
    assign rd_num[1] = dispatch[0].src1;
    assign rd_num[2] = dispatch[1].src0;
    assign rd_num[3] = dispatch[1].src1;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            set_valid[i] = dispatch[i].valid && (dispatch[i].dest != '0) && !kill;
            set_num[i]   = dispatch[i].dest;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            issue_d[i].valid      = dispatch[i].valid && !kill;
            issue_d[i].dest       = dispatch[i].dest;
            issue_d[i].src0       = dispatch[i].src0;
            issue_d[i].src1       = dispatch[i].src1;
            issue_d[i].src0_ready = (dispatch[i].src0 == '0) || !busy[2*i];
            issue_d[i].src1_ready = (dispatch[i].src1 == '0) || !busy[2*i+1];
        end

        // The set from slot 0 is not yet in the table, so the
        // intra-bundle dependence is resolved here
        if (older_writes && (dispatch[0].dest == dispatch[1].src0)) begin
            issue_d[1].src0_ready = 1'b0;
        end
        if (older_writes && (dispatch[0].dest == dispatch[1].src1)) begin
            issue_d[1].src1_ready = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {issue_d[1].valid, issue_d[0].valid};
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= issue_d;
    end

    always_comb begin
        issue = payload_q;
        for (int i = 0; i < 2; i++) begin
            issue[i].valid = valid_q[i];
        end
    end

endmodule
